//--- dma_rx_defs.svh
`ifndef DMA_RX_DEFS_SVH
`define DMA_RX_DEFS_SVH

// core and slot geometry
`define DMA_CORE_COUNT   16
`define DMA_SLOT_COUNT   16
`define DMA_CORE_NO_W    4
`define DMA_SLOT_NO_W    4

// significant bits of a slot base address inside a core
`define DMA_SLOT_ADDR_W  7

// descriptor fields
`define DMA_ADDR_W       20
`define DMA_LEN_W        16
`define DMA_RX_OFFSET    8'h0A
`define DMA_DEF_MAX_LEN  16'd2048

// one FIFO entry per slot of every core
`define DMA_FIFO_AW      8

// MAC side
`define DMA_PORT_COUNT   2
`define DMA_PEND_W       10

`endif

//--- dma_rx_pkg.sv
`default_nettype none

`include "dma_rx_defs.svh"

package dma_rx_pkg;

  typedef logic [`DMA_CORE_NO_W-1:0] core_no_t;
  typedef logic [`DMA_SLOT_NO_W-1:0] slot_no_t;
  typedef logic [`DMA_SLOT_ADDR_W-1:0] slot_addr_t;

  // core number in the upper bits, slot number below
  typedef logic [`DMA_CORE_NO_W+`DMA_SLOT_NO_W-1:0] slot_desc_t;

  typedef logic [`DMA_ADDR_W-1:0] rx_addr_t;
  typedef logic [`DMA_LEN_W-1:0] pkt_len_t;
  typedef logic [`DMA_PORT_COUNT-1:0] port_vec_t;

endpackage

`default_nettype wire

//--- desc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_defs.svh"

module desc_fifo
  import dma_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  slot_desc_t in_data,
  input  logic       in_valid,
  output logic       in_ready,
  output slot_desc_t out_data,
  output logic       out_valid,
  input  logic       out_ready
);

  localparam int unsigned DEPTH = 1 << `DMA_FIFO_AW;

  slot_desc_t mem [DEPTH];

  logic [`DMA_FIFO_AW-1:0] wr_ptr;
  logic [`DMA_FIFO_AW-1:0] rd_ptr;
  logic [`DMA_FIFO_AW:0]   count;
  logic                    do_wr;
  logic                    do_rd;

  assign in_ready  = (count != DEPTH[`DMA_FIFO_AW:0]);
  assign out_valid = (count != '0);
  assign do_wr     = in_valid && in_ready;
  assign do_rd     = out_valid && out_ready;

  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- slot_desc_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_defs.svh"

module slot_desc_source
  import dma_rx_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  slot_desc_t                 inject_desc,
  input  logic                       inject_valid,
  output logic                       inject_ready,
  input  slot_no_t                   slot_wr_no,
  input  slot_addr_t                 slot_wr_addr,
  input  logic                       slot_wr_valid,
  input  logic [`DMA_CORE_COUNT-1:0] drop_list,
  input  logic                       drop_list_valid,
  output logic                       head_valid,
  output rx_addr_t                   head_addr,
  input  logic                       head_pop
);

  slot_desc_t fifo_data;
  logic       fifo_valid;
  core_no_t   fifo_core;
  slot_no_t   fifo_slot;

  slot_addr_t slot_tab [`DMA_SLOT_COUNT];

  logic [`DMA_CORE_COUNT-1:0] drop_list_r;

  logic       head_full;
  logic       head_drop;
  logic       head_free;
  logic       head_load;
  core_no_t   head_core;
  slot_addr_t head_slot_addr;

  desc_fifo u_desc_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (inject_desc),
    .in_valid  (inject_valid),
    .in_ready  (inject_ready),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .out_ready (head_free)
  );

  assign fifo_core = fifo_data[`DMA_CORE_NO_W+`DMA_SLOT_NO_W-1 -: `DMA_CORE_NO_W];
  assign fifo_slot = fifo_data[`DMA_SLOT_NO_W-1:0];

  always_ff @(posedge clk) begin
    if (slot_wr_valid) begin
      slot_tab[slot_wr_no] <= slot_wr_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r <= '0;
    end else if (drop_list_valid) begin
      drop_list_r <= drop_list;
    end
  end

  // a dropped head frees itself, a live one waits for the arbiter
  assign head_free = !head_full || head_pop || head_drop;
  assign head_load = fifo_valid && head_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_full <= 1'b0;
    end else if (head_free) begin
      head_full <= fifo_valid;
    end
  end

  // table lookup and drop check happen as the head loads
  always_ff @(posedge clk) begin
    if (head_load) begin
      head_core      <= fifo_core;
      head_slot_addr <= slot_tab[fifo_slot];
      head_drop      <= drop_list_r[fifo_core];
    end
  end

  assign head_valid = head_full && !head_drop;
  assign head_addr  = {head_core, 1'b0, head_slot_addr, `DMA_RX_OFFSET};

endmodule

`default_nettype wire

//--- rx_port_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_defs.svh"

module rx_port_channel (
  input  logic clk,
  input  logic rst,
  input  logic head_valid,
  input  logic incoming,
  input  logic desc_ready,
  input  logic grant,
  output logic request
);

  // packets received by the MAC that still wait for a descriptor
  logic [`DMA_PEND_W-1:0] pend_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_cnt <= '0;
    end else if (incoming && !grant) begin
      pend_cnt <= pend_cnt + 1'b1;
    end else if (grant && !incoming) begin
      pend_cnt <= pend_cnt - 1'b1;
    end
  end

  // a packet arriving this cycle can be served at once
  assign request = head_valid && desc_ready && ((pend_cnt != '0) || incoming);

endmodule

`default_nettype wire

//--- port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
  import dma_rx_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  port_vec_t request,
  output port_vec_t grant,
  output logic      head_pop
);

  logic last_sel;
  logic sel;

  // prefer the port that was not served last
  always_comb begin
    sel = last_sel;
    if (last_sel && request[0]) begin
      sel = 1'b0;
    end else if (!last_sel && request[1]) begin
      sel = 1'b1;
    end
  end

  assign grant[0] = request[0] && !sel;
  assign grant[1] = request[1] && sel;
  assign head_pop = |grant;

  // reset to port 1 so port 0 goes first
  always_ff @(posedge clk) begin
    if (rst) begin
      last_sel <= 1'b1;
    end else if (head_pop) begin
      last_sel <= sel;
    end
  end

endmodule

`default_nettype wire

//--- dma_rx_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_defs.svh"

module dma_rx_dispatch
  import dma_rx_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  input  slot_desc_t                 inject_desc,
  input  logic                       inject_valid,
  output logic                       inject_ready,

  input  slot_no_t                   slot_wr_no,
  input  slot_addr_t                 slot_wr_addr,
  input  logic                       slot_wr_valid,

  input  logic [`DMA_CORE_COUNT-1:0] drop_list,
  input  logic                       drop_list_valid,
  input  pkt_len_t                   max_pkt_len,
  input  logic                       max_pkt_len_valid,

  input  port_vec_t                  incoming_pkt,
  input  port_vec_t                  rx_desc_ready,
  output port_vec_t                  rx_desc_valid,
  output rx_addr_t                   rx_desc_addr,
  output pkt_len_t                   rx_desc_len
);

  logic      head_valid;
  logic      head_pop;
  rx_addr_t  head_addr;
  port_vec_t request;
  port_vec_t grant;
  pkt_len_t  max_len_r;

  slot_desc_source u_slot_desc_source (
    .clk             (clk),
    .rst             (rst),
    .inject_desc     (inject_desc),
    .inject_valid    (inject_valid),
    .inject_ready    (inject_ready),
    .slot_wr_no      (slot_wr_no),
    .slot_wr_addr    (slot_wr_addr),
    .slot_wr_valid   (slot_wr_valid),
    .drop_list       (drop_list),
    .drop_list_valid (drop_list_valid),
    .head_valid      (head_valid),
    .head_addr       (head_addr),
    .head_pop        (head_pop)
  );

  for (genvar p = 0; p < `DMA_PORT_COUNT; p++) begin : g_chan
    rx_port_channel u_rx_port_channel (
      .clk        (clk),
      .rst        (rst),
      .head_valid (head_valid),
      .incoming   (incoming_pkt[p]),
      .desc_ready (rx_desc_ready[p]),
      .grant      (grant[p]),
      .request    (request[p])
    );
  end

  port_arbiter u_port_arbiter (
    .clk      (clk),
    .rst      (rst),
    .request  (request),
    .grant    (grant),
    .head_pop (head_pop)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      max_len_r <= `DMA_DEF_MAX_LEN;
    end else if (max_pkt_len_valid) begin
      max_len_r <= max_pkt_len;
    end
  end

  // address and length are shared, the valid bit picks the port
  assign rx_desc_valid = grant;
  assign rx_desc_addr  = head_addr;
  assign rx_desc_len   = max_len_r;

endmodule

`default_nettype wire

//--- tb_dma_rx_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_rx_defs.svh"

module tb_dma_rx_dispatch
  import dma_rx_pkg::*;
();

  // cycle budgets of reset and the six tests times four
  localparam int BUDGET_CYC = (10 + 60 + 120 + 120 + 400 + 150 + 100) * 4;

  // longest wait for the DUT to serve every pending packet
  localparam int DRAIN_CYC = 100;

  logic                       clk;
  logic                       rst;
  slot_desc_t                 inject_desc;
  logic                       inject_valid;
  logic                       inject_ready;
  slot_no_t                   slot_wr_no;
  slot_addr_t                 slot_wr_addr;
  logic                       slot_wr_valid;
  logic [`DMA_CORE_COUNT-1:0] drop_list;
  logic                       drop_list_valid;
  pkt_len_t                   max_pkt_len;
  logic                       max_pkt_len_valid;
  port_vec_t                  incoming_pkt;
  port_vec_t                  rx_desc_ready;
  port_vec_t                  rx_desc_valid;
  rx_addr_t                   rx_desc_addr;
  pkt_len_t                   rx_desc_len;

  // reference model state
  slot_addr_t                 model_tab [`DMA_SLOT_COUNT];
  logic [`DMA_CORE_COUNT-1:0] model_drop;
  pkt_len_t                   model_len;
  rx_addr_t                   model_q [$];
  int                         model_pend [2];
  int                         pulse_cnt [2];
  int                         deliv_cnt [2];
  int                         last_port;

  logic [31:0] lfsr;
  string       cur_test;
  int          err_count;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;

  dma_rx_dispatch u_dma_rx_dispatch (
    .clk               (clk),
    .rst               (rst),
    .inject_desc       (inject_desc),
    .inject_valid      (inject_valid),
    .inject_ready      (inject_ready),
    .slot_wr_no        (slot_wr_no),
    .slot_wr_addr      (slot_wr_addr),
    .slot_wr_valid     (slot_wr_valid),
    .drop_list         (drop_list),
    .drop_list_valid   (drop_list_valid),
    .max_pkt_len       (max_pkt_len),
    .max_pkt_len_valid (max_pkt_len_valid),
    .incoming_pkt      (incoming_pkt),
    .rx_desc_ready     (rx_desc_ready),
    .rx_desc_valid     (rx_desc_valid),
    .rx_desc_addr      (rx_desc_addr),
    .rx_desc_len       (rx_desc_len)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // core, a zero bit, the slot's table entry, then the fixed rx offset
  function automatic rx_addr_t ref_addr(input core_no_t core, input slot_no_t slot);
    return {core, 1'b0, model_tab[slot], 8'h0A};
  endfunction

  task automatic check_addr(input string what, input rx_addr_t exp, input rx_addr_t act);
    if (act !== exp) begin
      $display("** Error: %s: %s expected %h actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_len(input string what, input pkt_len_t exp, input pkt_len_t act);
    if (act !== exp) begin
      $display("** Error: %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_ports(input string what, input port_vec_t exp, input port_vec_t act);
    if (act !== exp) begin
      $display("** Error: %s: %s expected %b actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s: %s expected %b actual %b", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("** Error: %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error in %s: %s", cur_test, msg);
    err_count++;
  endtask

  // compare process samples mid-cycle while inputs and outputs are settled
  always @(negedge clk) begin
    rx_addr_t exp_addr;
    logic     both_req;
    if (!rst) begin
      both_req = (rx_desc_ready == 2'b11)
                 && (model_pend[0] > 0 || incoming_pkt[0])
                 && (model_pend[1] > 0 || incoming_pkt[1]);
      if (rx_desc_valid == 2'b11) begin
        report_failure("rx_desc_valid is high on both ports");
      end
      for (int p = 0; p < 2; p++) begin
        if (rx_desc_valid[p]) begin
          if (!rx_desc_ready[p]) begin
            report_failure($sformatf("port %0d got a descriptor while not ready", p));
          end
          if (model_pend[p] == 0 && !incoming_pkt[p]) begin
            report_failure($sformatf("port %0d got a descriptor with no packet", p));
          end
          if (model_q.size() == 0) begin
            report_failure("descriptor delivered while none was expected");
          end else begin
            exp_addr = model_q.pop_front();
            check_addr("rx_desc_addr", exp_addr, rx_desc_addr);
          end
          check_len("rx_desc_len", model_len, rx_desc_len);
          if (model_drop[rx_desc_addr[19:16]]) begin
            report_failure("descriptor of a dropped core was delivered");
          end
          if (both_req && p == last_port) begin
            report_failure($sformatf("port %0d served twice while both requested", p));
          end
          last_port = p;
          deliv_cnt[p]++;
        end
        if (incoming_pkt[p]) begin
          pulse_cnt[p]++;
        end
        model_pend[p] = model_pend[p] + int'(incoming_pkt[p]) - int'(rx_desc_valid[p]);
      end
      // the DUT transfers at the next edge, so the model follows afterwards
      if (inject_valid && inject_ready && !model_drop[inject_desc[7:4]]) begin
        model_q.push_back(ref_addr(inject_desc[7:4], inject_desc[3:0]));
      end
      if (max_pkt_len_valid) begin
        model_len = max_pkt_len;
      end
    end
  end

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = err_count;
    pulse_cnt = '{0, 0};
    deliv_cnt = '{0, 0};
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, err_count - test_err_start);
    end
  endtask

  task automatic write_table();
    slot_addr_t v;
    for (int i = 0; i < `DMA_SLOT_COUNT; i++) begin
      v = slot_addr_t'(rand_bits(7));
      @(posedge clk);
      slot_wr_no    <= slot_no_t'(i);
      slot_wr_addr  <= v;
      slot_wr_valid <= 1'b1;
      model_tab[i] = v;
    end
    @(posedge clk);
    slot_wr_valid <= 1'b0;
  endtask

  task automatic set_drop(input logic [`DMA_CORE_COUNT-1:0] v);
    @(posedge clk);
    drop_list       <= v;
    drop_list_valid <= 1'b1;
    model_drop = v;
    @(posedge clk);
    drop_list_valid <= 1'b0;
  endtask

  task automatic set_max_len(input pkt_len_t v);
    @(posedge clk);
    max_pkt_len       <= v;
    max_pkt_len_valid <= 1'b1;
    @(posedge clk);
    max_pkt_len_valid <= 1'b0;
  endtask

  task automatic inject_random(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      inject_desc  <= slot_desc_t'(rand_bits(8));
      inject_valid <= 1'b1;
      do begin
        @(negedge clk);
      end while (!inject_ready);
    end
    @(posedge clk);
    inject_valid <= 1'b0;
  endtask

  task automatic pulse_ports(input port_vec_t pattern, input int n);
    repeat (n) begin
      @(posedge clk);
      incoming_pkt <= pattern;
    end
    @(posedge clk);
    incoming_pkt <= '0;
  endtask

  // each port pulses with probability one quarter
  task automatic random_pulses(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = rand_bits(4);
      @(posedge clk);
      incoming_pkt <= {r[2] & r[3], r[0] & r[1]};
    end
    @(posedge clk);
    incoming_pkt <= '0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while ((model_pend[0] != 0 || model_pend[1] != 0) && n < DRAIN_CYC);
    if (model_pend[0] != 0 || model_pend[1] != 0) begin
      report_failure($sformatf("packets still pending after %0d cycles", DRAIN_CYC));
    end
  endtask

  initial begin
    pkt_len_t new_len;
    int       kept;
    inject_desc       = '0;
    inject_valid      = 1'b0;
    slot_wr_no        = '0;
    slot_wr_addr      = '0;
    slot_wr_valid     = 1'b0;
    drop_list         = '0;
    drop_list_valid   = 1'b0;
    max_pkt_len       = '0;
    max_pkt_len_valid = 1'b0;
    incoming_pkt      = '0;
    rx_desc_ready     = 2'b11;
    lfsr              = 32'h7e0194ae;
    model_drop        = '0;
    model_len         = 16'd2048;
    model_pend        = '{0, 0};
    last_port         = 1;
    err_count         = 0;
    tests_run         = 0;
    tests_failed      = 0;
    cur_test          = "reset";
    rst               = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    start_test("reset_state");
    @(negedge clk);
    check_ports("rx_desc_valid", '0, rx_desc_valid);
    check_flag("inject_ready", 1'b1, inject_ready);
    write_table();
    inject_random(1);
    pulse_ports(2'b01, 1);
    wait_drain();
    check_count("port 0 deliveries", 1, deliv_cnt[0]);
    end_test();

    start_test("slot_table");
    write_table();
    inject_random(24);
    pulse_ports(2'b11, 12);
    wait_drain();
    check_count("undelivered descriptors", 0, model_q.size());
    end_test();

    start_test("drop_list");
    set_drop(`DMA_CORE_COUNT'(rand_bits(`DMA_CORE_COUNT)));
    inject_random(24);
    kept = model_q.size();
    pulse_ports(2'b01, kept);
    wait_drain();
    check_count("undelivered descriptors", 0, model_q.size());
    // dropped entries behind the last kept one leave the head stage one per cycle
    repeat (24) @(posedge clk);
    end_test();

    start_test("random_traffic");
    set_drop('0);
    inject_random(100);
    random_pulses(120);
    wait_drain();
    check_count("port 0 deliveries", pulse_cnt[0], deliv_cnt[0]);
    check_count("port 1 deliveries", pulse_cnt[1], deliv_cnt[1]);
    end_test();

    start_test("backpressure");
    inject_random(12);
    @(posedge clk);
    rx_desc_ready <= 2'b01;
    pulse_ports(2'b11, 6);
    do begin
      @(posedge clk);
    end while (model_pend[0] != 0);
    repeat (20) @(posedge clk);
    check_count("port 1 pending while not ready", 6, model_pend[1]);
    check_count("port 1 deliveries while not ready", 0, deliv_cnt[1]);
    rx_desc_ready <= 2'b11;
    wait_drain();
    check_count("port 1 deliveries after ready", 6, deliv_cnt[1]);
    end_test();

    start_test("max_len");
    new_len = pkt_len_t'(rand_bits(16));
    set_max_len(new_len);
    inject_random(8);
    pulse_ports(2'b10, 8);
    wait_drain();
    check_count("port 1 deliveries", 8, deliv_cnt[1]);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (BUDGET_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles during %s", BUDGET_CYC, cur_test);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dma_rx_dispatch.f
+incdir+.
dma_rx_pkg.sv
desc_fifo.sv
slot_desc_source.sv
rx_port_channel.sv
port_arbiter.sv
dma_rx_dispatch.sv
tb_dma_rx_dispatch.sv

//--- Makefile
TOP       ?= tb_dma_rx_dispatch
FILELIST  ?= dma_rx_dispatch.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
